/* verilog/ccu_pkg.sv */
package ccu_pkg;

  // Bus widths
  localparam int unsigned ADDR_WIDTH    = 32;
  localparam int unsigned DATA_WIDTH    = 32;
  localparam int unsigned SLV_ID_WIDTH  = 3;
  localparam int unsigned MAX_PORTS_LOG = 1;

  // Snoop flag, then port index, then upstream ID
  localparam int unsigned MST_ID_WIDTH  = 1 + MAX_PORTS_LOG + SLV_ID_WIDTH;

  // Cache line index used by the conflict manager
  localparam int unsigned CM_ADDR_BASE  = 6;
  localparam int unsigned CM_ADDR_WIDTH = 10;

  localparam int unsigned TRACK_CAPACITY = 8;
  localparam int unsigned ACK_DEPTH      = 2;

  typedef logic [SLV_ID_WIDTH-1:0]  slv_id_t;
  typedef logic [MST_ID_WIDTH-1:0]  mst_id_t;
  typedef logic [CM_ADDR_WIDTH-1:0] cm_addr_t;

endpackage

/* verilog/ccu_track_if.sv */
`timescale 1ns/1ps

interface ccu_track_if;
  import ccu_pkg::*;

  // Snooping AR accepted by the mux
  logic     trk_valid;
  logic     trk_ready;
  mst_id_t  trk_id;
  cm_addr_t trk_addr;

  // R beat handed over to a port
  logic     rsp_valid;
  logic     rsp_last;
  mst_id_t  rsp_id;
  logic     rsp_hold;

  modport mux (
    output trk_valid, trk_addr, trk_id,
    output rsp_valid, rsp_last, rsp_id,
    input  trk_ready, rsp_hold
  );

  modport queue (
    input  trk_valid, trk_id, trk_addr,
    output trk_ready
  );

  modport tracker (
    input  rsp_valid, rsp_last, rsp_id,
    output rsp_hold
  );

endinterface

/* verilog/rd_port_mux.sv */
`timescale 1ns/1ps

module rd_port_mux #(
  parameter int unsigned NUM_PORTS = 2
) (
  input  logic                                           clk_i,
  input  logic                                           rst_i,

  input  logic             [NUM_PORTS-1:0]                slv_ar_valid_i,
  output logic             [NUM_PORTS-1:0]                slv_ar_ready_o,
  input  logic             [NUM_PORTS-1:0][ccu_pkg::ADDR_WIDTH-1:0] slv_ar_addr_i,
  input  ccu_pkg::slv_id_t [NUM_PORTS-1:0]                slv_ar_id_i,
  input  logic             [NUM_PORTS-1:0]                slv_ar_snoop_i,

  output logic             [NUM_PORTS-1:0]                slv_r_valid_o,
  input  logic             [NUM_PORTS-1:0]                slv_r_ready_i,
  output logic             [NUM_PORTS-1:0][ccu_pkg::DATA_WIDTH-1:0] slv_r_data_o,
  output ccu_pkg::slv_id_t [NUM_PORTS-1:0]                slv_r_id_o,
  output logic             [NUM_PORTS-1:0]                slv_r_last_o,

  output logic                                           mem_ar_valid_o,
  input  logic                                           mem_ar_ready_i,
  output logic             [ccu_pkg::ADDR_WIDTH-1:0]      mem_ar_addr_o,
  output ccu_pkg::mst_id_t                               mem_ar_id_o,
  input  logic                                           mem_r_valid_i,
  output logic                                           mem_r_ready_o,
  input  logic             [ccu_pkg::DATA_WIDTH-1:0]      mem_r_data_i,
  input  ccu_pkg::mst_id_t                               mem_r_id_i,
  input  logic                                           mem_r_last_i,

  ccu_track_if.mux                                       trk
);
  import ccu_pkg::*;

  logic [MAX_PORTS_LOG-1:0] rr_q;
  logic [MAX_PORTS_LOG-1:0] gnt_q;
  logic                     lock_q;
  logic [MAX_PORTS_LOG-1:0] sel;
  logic                     sel_valid;
  logic                     sel_snoop;
  logic                     ar_xfer;
  logic [MAX_PORTS_LOG-1:0] r_port;
  logic                     hold;

  //////////////////////////////////////////////////////////////////////
  // AR arbitration
  //////////////////////////////////////////////////////////////////////

  // First requester at or after the round-robin pointer
  always_comb begin
    sel = rr_q;
    if (lock_q) begin
      sel = gnt_q;
    end else begin
      for (int k = NUM_PORTS - 1; k >= 0; k--) begin
        if (slv_ar_valid_i[(int'(rr_q) + k) % NUM_PORTS]) begin
          sel = MAX_PORTS_LOG'((int'(rr_q) + k) % NUM_PORTS);
        end
      end
    end
  end

  assign sel_valid = slv_ar_valid_i[sel];
  assign sel_snoop = slv_ar_snoop_i[sel];

  // A snooping read stalls while the address queue is full
  assign mem_ar_valid_o = sel_valid && (!sel_snoop || trk.trk_ready);
  assign ar_xfer        = mem_ar_valid_o && mem_ar_ready_i;

  always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      slv_ar_ready_o[p] = (sel == MAX_PORTS_LOG'(p)) && mem_ar_ready_i &&
                          (!sel_snoop || trk.trk_ready);
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rr_q   <= '0;
      gnt_q  <= '0;
      lock_q <= 1'b0;
    end else if (ar_xfer) begin
      lock_q <= 1'b0;
      rr_q   <= MAX_PORTS_LOG'((int'(sel) + 1) % NUM_PORTS);
    end else if (sel_valid) begin
      // Keep the grant until the request goes through
      lock_q <= 1'b1;
      gnt_q  <= sel;
    end
  end

  assign mem_ar_addr_o = slv_ar_addr_i[sel];
  assign mem_ar_id_o   = {sel_snoop, sel, slv_ar_id_i[sel]};

  // Tracking fork, pushes together with the memory transfer
  assign trk.trk_valid = sel_valid && sel_snoop && mem_ar_ready_i;
  assign trk.trk_id    = mem_ar_id_o;
  assign trk.trk_addr  = slv_ar_addr_i[sel][CM_ADDR_BASE +: CM_ADDR_WIDTH];

  //////////////////////////////////////////////////////////////////////
  // R routing
  //////////////////////////////////////////////////////////////////////

  assign r_port = mem_r_id_i[SLV_ID_WIDTH +: MAX_PORTS_LOG];
  assign hold   = trk.rsp_hold;

  always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      slv_r_valid_o[p] = mem_r_valid_i && !hold && (r_port == MAX_PORTS_LOG'(p));
      slv_r_data_o[p]  = mem_r_data_i;
      slv_r_id_o[p]    = mem_r_id_i[SLV_ID_WIDTH-1:0];
      slv_r_last_o[p]  = mem_r_last_i;
    end
  end

  assign mem_r_ready_o = slv_r_ready_i[r_port] && !hold;

  // Beat reported only when it actually reaches the port
  assign trk.rsp_valid = mem_r_valid_i && mem_r_ready_o;
  assign trk.rsp_last  = mem_r_last_i;
  assign trk.rsp_id    = mem_r_id_i;

endmodule

/* verilog/cm_addr_queue.sv */
`timescale 1ns/1ps

module cm_addr_queue #(
  parameter int unsigned TRACK_CAPACITY = ccu_pkg::TRACK_CAPACITY
) (
  input  logic              clk_i,
  input  logic              rst_i,
  ccu_track_if.queue        trk,
  input  logic              pop_i,
  input  ccu_pkg::mst_id_t  pop_id_i,
  output ccu_pkg::cm_addr_t addr_o
);
  import ccu_pkg::*;

  localparam int unsigned IDX_W = (TRACK_CAPACITY > 1) ? $clog2(TRACK_CAPACITY) : 1;

  // Compacted storage, entry 0 is the oldest
  mst_id_t  [TRACK_CAPACITY-1:0] id_q, id_sh, id_d;
  cm_addr_t [TRACK_CAPACITY-1:0] addr_q, addr_sh, addr_d;
  logic     [TRACK_CAPACITY-1:0] valid_q, valid_sh, valid_d;
  logic     [IDX_W-1:0]          match_idx;
  logic     [IDX_W-1:0]          push_idx;
  logic                          match_found;
  logic                          remove;
  logic                          push;

  assign trk.trk_ready = !valid_q[TRACK_CAPACITY-1];
  assign push          = trk.trk_valid && trk.trk_ready;

  // Oldest matching entry wins
  always_comb begin
    match_found = 1'b0;
    match_idx   = '0;
    for (int i = TRACK_CAPACITY - 1; i >= 0; i--) begin
      if (valid_q[i] && (id_q[i] == pop_id_i)) begin
        match_found = 1'b1;
        match_idx   = IDX_W'(i);
      end
    end
  end

  assign remove = pop_i && match_found;
  assign addr_o = addr_q[match_idx];

  // Close the gap left by a removed entry
  always_comb begin
    for (int i = 0; i < TRACK_CAPACITY; i++) begin
      valid_sh[i] = valid_q[i];
      id_sh[i]    = id_q[i];
      addr_sh[i]  = addr_q[i];
      if (remove && (i >= int'(match_idx))) begin
        if (i < TRACK_CAPACITY - 1) begin
          valid_sh[i] = valid_q[i+1];
          id_sh[i]    = id_q[i+1];
          addr_sh[i]  = addr_q[i+1];
        end else begin
          valid_sh[i] = 1'b0;
        end
      end
    end
  end

  always_comb begin
    push_idx = '0;
    for (int i = TRACK_CAPACITY - 1; i >= 0; i--) begin
      if (!valid_sh[i]) begin
        push_idx = IDX_W'(i);
      end
    end
    valid_d = valid_sh;
    id_d    = id_sh;
    addr_d  = addr_sh;
    if (push) begin
      valid_d[push_idx] = 1'b1;
      id_d[push_idx]    = trk.trk_id;
      addr_d[push_idx]  = trk.trk_addr;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    id_q   <= id_d;
    addr_q <= addr_d;
  end

endmodule

/* verilog/rack_tracker.sv */
`timescale 1ns/1ps

module rack_tracker #(
  parameter int unsigned NUM_PORTS = 2,
  parameter int unsigned ACK_DEPTH = ccu_pkg::ACK_DEPTH
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  ccu_track_if.tracker         rsp,
  input  logic [NUM_PORTS-1:0] rack_i,
  output logic                 pop_o,
  output ccu_pkg::mst_id_t     pop_id_o,
  input  ccu_pkg::cm_addr_t    addr_i,
  output logic                 cm_req_o,
  output ccu_pkg::cm_addr_t    cm_addr_o
);
  import ccu_pkg::*;

  localparam int unsigned PTR_W = (ACK_DEPTH > 1) ? $clog2(ACK_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(ACK_DEPTH + 1);

  mst_id_t                  id_mem [ACK_DEPTH];
  logic [PTR_W-1:0]         wr_ptr_q;
  logic [PTR_W-1:0]         rd_ptr_q;
  logic [CNT_W-1:0]         count_q;
  logic                     full;
  logic                     empty;
  logic                     push;
  logic                     pop;
  mst_id_t                  head_id;
  logic [MAX_PORTS_LOG-1:0] head_port;

  assign full  = (count_q == CNT_W'(ACK_DEPTH));
  assign empty = (count_q == '0);

  // Last beat of a snooping read waits here while no slot is free
  assign rsp.rsp_hold = full && rsp.rsp_last && rsp.rsp_id[MST_ID_WIDTH-1];

  assign push = rsp.rsp_valid && rsp.rsp_last && rsp.rsp_id[MST_ID_WIDTH-1];

  assign head_id   = id_mem[rd_ptr_q];
  assign head_port = head_id[SLV_ID_WIDTH +: MAX_PORTS_LOG];

  // Only the owner of the oldest pending read may acknowledge
  assign pop = !empty && rack_i[head_port];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(ACK_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(ACK_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      id_mem[wr_ptr_q] <= rsp.rsp_id;
    end
  end

  assign pop_o     = pop;
  assign pop_id_o  = head_id;
  assign cm_req_o  = pop;
  assign cm_addr_o = addr_i;

endmodule

/* verilog/ccu_read_top.sv */
`timescale 1ns/1ps

module ccu_read_top #(
  parameter int unsigned NUM_PORTS      = 2,
  parameter int unsigned TRACK_CAPACITY = ccu_pkg::TRACK_CAPACITY,
  parameter int unsigned ACK_DEPTH      = ccu_pkg::ACK_DEPTH
) (
  input  logic                                           clk_i,
  input  logic                                           rst_i,

  input  logic             [NUM_PORTS-1:0]                slv_ar_valid_i,
  output logic             [NUM_PORTS-1:0]                slv_ar_ready_o,
  input  logic             [NUM_PORTS-1:0][ccu_pkg::ADDR_WIDTH-1:0] slv_ar_addr_i,
  input  ccu_pkg::slv_id_t [NUM_PORTS-1:0]                slv_ar_id_i,
  input  logic             [NUM_PORTS-1:0]                slv_ar_snoop_i,
  output logic             [NUM_PORTS-1:0]                slv_r_valid_o,
  input  logic             [NUM_PORTS-1:0]                slv_r_ready_i,
  output logic             [NUM_PORTS-1:0][ccu_pkg::DATA_WIDTH-1:0] slv_r_data_o,
  output ccu_pkg::slv_id_t [NUM_PORTS-1:0]                slv_r_id_o,
  output logic             [NUM_PORTS-1:0]                slv_r_last_o,
  input  logic             [NUM_PORTS-1:0]                slv_rack_i,

  output logic                                           mem_ar_valid_o,
  input  logic                                           mem_ar_ready_i,
  output logic             [ccu_pkg::ADDR_WIDTH-1:0]      mem_ar_addr_o,
  output ccu_pkg::mst_id_t                               mem_ar_id_o,
  input  logic                                           mem_r_valid_i,
  output logic                                           mem_r_ready_o,
  input  logic             [ccu_pkg::DATA_WIDTH-1:0]      mem_r_data_i,
  input  ccu_pkg::mst_id_t                               mem_r_id_i,
  input  logic                                           mem_r_last_i,

  output logic                                           cm_req_o,
  output ccu_pkg::cm_addr_t                              cm_addr_o
);
  import ccu_pkg::*;

  ccu_track_if trk_if ();

  logic     lookup_pop;
  mst_id_t  lookup_id;
  cm_addr_t lookup_addr;

  rd_port_mux #(
    .NUM_PORTS (NUM_PORTS)
  ) i_rd_port_mux (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .slv_ar_valid_i (slv_ar_valid_i),
    .slv_ar_ready_o (slv_ar_ready_o),
    .slv_ar_addr_i  (slv_ar_addr_i),
    .slv_ar_id_i    (slv_ar_id_i),
    .slv_ar_snoop_i (slv_ar_snoop_i),
    .slv_r_valid_o  (slv_r_valid_o),
    .slv_r_ready_i  (slv_r_ready_i),
    .slv_r_data_o   (slv_r_data_o),
    .slv_r_id_o     (slv_r_id_o),
    .slv_r_last_o   (slv_r_last_o),
    .mem_ar_valid_o (mem_ar_valid_o),
    .mem_ar_ready_i (mem_ar_ready_i),
    .mem_ar_addr_o  (mem_ar_addr_o),
    .mem_ar_id_o    (mem_ar_id_o),
    .mem_r_valid_i  (mem_r_valid_i),
    .mem_r_ready_o  (mem_r_ready_o),
    .mem_r_data_i   (mem_r_data_i),
    .mem_r_id_i     (mem_r_id_i),
    .mem_r_last_i   (mem_r_last_i),
    .trk            (trk_if)
  );

  cm_addr_queue #(
    .TRACK_CAPACITY (TRACK_CAPACITY)
  ) i_cm_addr_queue (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .trk      (trk_if),
    .pop_i    (lookup_pop),
    .pop_id_i (lookup_id),
    .addr_o   (lookup_addr)
  );

  rack_tracker #(
    .NUM_PORTS (NUM_PORTS),
    .ACK_DEPTH (ACK_DEPTH)
  ) i_rack_tracker (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .rsp       (trk_if),
    .rack_i    (slv_rack_i),
    .pop_o     (lookup_pop),
    .pop_id_o  (lookup_id),
    .addr_i    (lookup_addr),
    .cm_req_o  (cm_req_o),
    .cm_addr_o (cm_addr_o)
  );

endmodule

/* verification/tb_ccu_read.sv */
`timescale 1ns/1ps

module tb_ccu_read;
  import ccu_pkg::*;

  localparam int unsigned NUM_PORTS = 2;
  localparam int unsigned TIMEOUT   = 200;

  logic                                 clk_i;
  logic                                 rst_i;
  logic    [NUM_PORTS-1:0]              slv_ar_valid_i;
  logic    [NUM_PORTS-1:0]              slv_ar_ready_o;
  logic    [NUM_PORTS-1:0][ADDR_WIDTH-1:0] slv_ar_addr_i;
  slv_id_t [NUM_PORTS-1:0]              slv_ar_id_i;
  logic    [NUM_PORTS-1:0]              slv_ar_snoop_i;
  logic    [NUM_PORTS-1:0]              slv_r_valid_o;
  logic    [NUM_PORTS-1:0]              slv_r_ready_i;
  logic    [NUM_PORTS-1:0][DATA_WIDTH-1:0] slv_r_data_o;
  slv_id_t [NUM_PORTS-1:0]              slv_r_id_o;
  logic    [NUM_PORTS-1:0]              slv_r_last_o;
  logic    [NUM_PORTS-1:0]              slv_rack_i;
  logic                                 mem_ar_valid_o;
  logic                                 mem_ar_ready_i;
  logic    [ADDR_WIDTH-1:0]             mem_ar_addr_o;
  mst_id_t                              mem_ar_id_o;
  logic                                 mem_r_valid_i;
  logic                                 mem_r_ready_o;
  logic    [DATA_WIDTH-1:0]             mem_r_data_i;
  mst_id_t                              mem_r_id_i;
  logic                                 mem_r_last_i;
  logic                                 cm_req_o;
  cm_addr_t                             cm_addr_o;

  integer seed = 32'h627b;

  // Accepted reads per port, in order
  logic [ADDR_WIDTH-1:0]    sb_addr  [NUM_PORTS][64];
  slv_id_t                  sb_id    [NUM_PORTS][64];
  logic                     sb_snoop [NUM_PORTS][64];
  logic [5:0]               sb_wr    [NUM_PORTS];
  logic [5:0]               sb_rd    [NUM_PORTS];
  slv_id_t                  head_id  [NUM_PORTS];
  logic [DATA_WIDTH-1:0]    head_data [NUM_PORTS];
  int unsigned              starve   [NUM_PORTS];
  // Memory model request queue
  logic [ADDR_WIDTH-1:0]    mq_addr [64];
  mst_id_t                  mq_id   [64];
  logic                     mq_snoop [64];
  logic [5:0]               mq_wr;
  logic [5:0]               mq_rd;
  // Acknowledgements still owed
  logic [MAX_PORTS_LOG-1:0] ack_port [4];
  cm_addr_t                 ack_addr [4];
  logic [1:0]               ack_wr;
  logic [1:0]               ack_rd;
  int unsigned              ack_count;
  logic                     ack_push;
  logic                     exp_req;
  cm_addr_t                 exp_cm_addr;
  logic [NUM_PORTS-1:0]     ar_done_q;
  logic                     mem_r_done_q;

  ccu_read_top #(
    .NUM_PORTS (NUM_PORTS)
  ) DUT (.*);

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("** FAIL **");
    $fatal(1);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  assign exp_req     = (ack_count != 0) && slv_rack_i[ack_port[ack_rd]];
  assign exp_cm_addr = ack_addr[ack_rd];

  always_comb begin
    ack_push = 1'b0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      head_id[p]   = sb_id[p][sb_rd[p]];
      head_data[p] = sb_addr[p][sb_rd[p]] ^ 32'hA5A5_0000;
      if (slv_r_valid_o[p] && slv_r_ready_i[p] && sb_snoop[p][sb_rd[p]]) begin
        ack_push = 1'b1;
      end
    end
  end

  always @(posedge clk_i) begin
    ar_done_q    <= slv_ar_valid_i & slv_ar_ready_o;
    mem_r_done_q <= mem_r_valid_i && mem_r_ready_o;
    if (rst_i) begin
      mq_wr     <= '0;
      ack_wr    <= '0;
      ack_rd    <= '0;
      ack_count <= 0;
      for (int p = 0; p < NUM_PORTS; p++) begin
        sb_wr[p]  <= '0;
        sb_rd[p]  <= '0;
        starve[p] <= 0;
      end
    end else begin
      if (mem_ar_valid_o && mem_ar_ready_i) begin
        mq_addr[mq_wr]  <= mem_ar_addr_o;
        mq_id[mq_wr]    <= mem_ar_id_o;
        mq_snoop[mq_wr] <= |(slv_ar_valid_i & slv_ar_ready_o & slv_ar_snoop_i);
        mq_wr           <= mq_wr + 1'b1;
      end
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (slv_ar_valid_i[p] && slv_ar_ready_o[p]) begin
          sb_addr[p][sb_wr[p]]  <= slv_ar_addr_i[p];
          sb_id[p][sb_wr[p]]    <= slv_ar_id_i[p];
          sb_snoop[p][sb_wr[p]] <= slv_ar_snoop_i[p];
          sb_wr[p]              <= sb_wr[p] + 1'b1;
          starve[p]             <= 0;
        end else if (slv_ar_valid_i[p] && mem_ar_valid_o && mem_ar_ready_i) begin
          // Another port went first while this one waited
          starve[p] <= starve[p] + 1;
        end
        if (slv_r_valid_o[p] && slv_r_ready_i[p]) begin
          sb_rd[p] <= sb_rd[p] + 1'b1;
          if (sb_snoop[p][sb_rd[p]]) begin
            ack_port[ack_wr] <= MAX_PORTS_LOG'(p);
            ack_addr[ack_wr] <= sb_addr[p][sb_rd[p]][15:6];
          end
        end
      end
      if (ack_push) begin
        ack_wr <= ack_wr + 1'b1;
      end
      if (exp_req) begin
        ack_rd <= ack_rd + 1'b1;
      end
      ack_count <= ack_count + ack_push - exp_req;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port_checks
    assert property (@(posedge clk_i) disable iff (rst_i)
        slv_r_valid_o[p] |-> (sb_rd[p] != sb_wr[p]))
      else stop_with_failure($sformatf("Response on port %0d with no read outstanding", p));
    assert property (@(posedge clk_i) disable iff (rst_i)
        slv_r_valid_o[p] |-> (slv_r_id_o[p] == head_id[p]))
      else stop_with_failure($sformatf("ERR slv_r_id_o[%0d] got %h exp %h", p,
                             $sampled(slv_r_id_o[p]), $sampled(head_id[p])));
    assert property (@(posedge clk_i) disable iff (rst_i)
        slv_r_valid_o[p] |-> (slv_r_data_o[p] == head_data[p]))
      else stop_with_failure($sformatf("ERR slv_r_data_o[%0d] got %h exp %h", p,
                             $sampled(slv_r_data_o[p]), $sampled(head_data[p])));
    // Every response of the memory model is a single beat
    assert property (@(posedge clk_i) disable iff (rst_i)
        slv_r_valid_o[p] |-> slv_r_last_o[p])
      else stop_with_failure($sformatf("ERR slv_r_last_o[%0d] got %h exp 1", p,
                             $sampled(slv_r_last_o[p])));
    assert property (@(posedge clk_i) disable iff (rst_i) starve[p] <= NUM_PORTS)
      else stop_with_failure($sformatf("Port %0d starved by the arbiter", p));
  end

  assert property (@(posedge clk_i) $fell(rst_i) |->
      (!cm_req_o && !mem_ar_valid_o && (slv_r_valid_o == '0)))
    else stop_with_failure("Outputs not idle after reset");

  assert property (@(posedge clk_i) disable iff (rst_i) cm_req_o == exp_req)
    else stop_with_failure($sformatf("ERR cm_req_o got %h exp %h",
                           $sampled(cm_req_o), $sampled(exp_req)));

  assert property (@(posedge clk_i) disable iff (rst_i) exp_req |-> (cm_addr_o == exp_cm_addr))
    else stop_with_failure($sformatf("ERR cm_addr_o got %h exp %h",
                           $sampled(cm_addr_o), $sampled(exp_cm_addr)));

  // Snooping last beat must wait while two acknowledgements are owed
  assert property (@(posedge clk_i) disable iff (rst_i)
      ((ack_count == ACK_DEPTH) && mem_r_valid_i && mem_r_last_i && mq_snoop[mq_rd])
      |-> (slv_r_valid_o == '0))
    else stop_with_failure($sformatf("ERR slv_r_valid_o got %h exp 0",
                           $sampled(slv_r_valid_o)));

  //////////////////////////////////////////////////////////////////////
  // Memory model and stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin : memory_model
    int unsigned delay;
    int unsigned waited;
    mq_rd = '0;
    forever begin
      @(negedge clk_i);
      if (!rst_i && (mq_rd != mq_wr)) begin
        delay = {$random(seed)} % 6;
        repeat (delay) @(negedge clk_i);
        mem_r_valid_i = 1'b1;
        mem_r_data_i  = mq_addr[mq_rd] ^ 32'hA5A5_0000;
        mem_r_id_i    = mq_id[mq_rd];
        mem_r_last_i  = 1'b1;
        waited = 0;
        do begin
          @(negedge clk_i);
          waited++;
          if (waited > TIMEOUT) begin
            stop_with_failure("Memory response was never taken");
          end
        end while (!mem_r_done_q);
        mem_r_valid_i = 1'b0;
        mem_r_last_i  = 1'b0;
        mq_rd         = mq_rd + 1'b1;
      end
    end
  end

  initial begin : ar_ready_gen
    forever begin
      @(negedge clk_i);
      mem_ar_ready_i = ({$random(seed)} % 4) != 0;
    end
  end

  // Called on a falling edge, returns on the falling edge after acceptance
  task automatic issue_read(input int p, input logic [ADDR_WIDTH-1:0] addr,
                            input slv_id_t id, input logic snoop);
    int unsigned waited;
    waited = 0;
    slv_ar_valid_i[p] = 1'b1;
    slv_ar_addr_i[p]  = addr;
    slv_ar_id_i[p]    = id;
    slv_ar_snoop_i[p] = snoop;
    do begin
      @(negedge clk_i);
      waited++;
      if (waited > TIMEOUT) begin
        stop_with_failure($sformatf("Read on port %0d was never accepted", p));
      end
    end while (!ar_done_q[p]);
  endtask

  task automatic single_read(input int p, input logic [ADDR_WIDTH-1:0] addr,
                             input slv_id_t id, input logic snoop);
    issue_read(p, addr, id, snoop);
    slv_ar_valid_i[p] = 1'b0;
  endtask

  task automatic stream_reads(input int p, input int n);
    for (int i = 0; i < n; i++) begin
      issue_read(p, $random(seed), slv_id_t'($random(seed)), 1'b0);
    end
    slv_ar_valid_i[p] = 1'b0;
  endtask

  task automatic send_rack(input int p);
    slv_rack_i[p] = 1'b1;
    @(negedge clk_i);
    slv_rack_i[p] = 1'b0;
  endtask

  task automatic wait_drained();
    int unsigned waited;
    waited = 0;
    while ((mq_rd != mq_wr) || mem_r_valid_i ||
           (sb_rd[0] != sb_wr[0]) || (sb_rd[1] != sb_wr[1])) begin
      @(negedge clk_i);
      waited++;
      if (waited > TIMEOUT) begin
        stop_with_failure("Outstanding reads did not complete");
      end
    end
  endtask

  initial begin : stimulus
    rst_i          = 1'b1;
    slv_ar_valid_i = '0;
    slv_ar_addr_i  = '0;
    slv_ar_id_i    = '0;
    slv_ar_snoop_i = '0;
    slv_r_ready_i  = '1;
    slv_rack_i     = '0;
    mem_ar_ready_i = 1'b1;
    mem_r_valid_i  = 1'b0;
    mem_r_data_i   = '0;
    mem_r_id_i     = '0;
    mem_r_last_i   = 1'b0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    // Racks right after reset find nothing to acknowledge
    slv_rack_i = '1;
    @(negedge clk_i);
    slv_rack_i = '0;

    // Plain reads, then racks with nothing owed
    single_read(0, 32'h0000_1040, 3'd1, 1'b0);
    single_read(1, 32'h0000_2080, 3'd2, 1'b0);
    wait_drained();
    send_rack(0);
    send_rack(1);

    fork
      stream_reads(0, 12);
      stream_reads(1, 12);
    join
    wait_drained();

    // Rack from the wrong port is ignored
    single_read(0, 32'h1234_5678, 3'd5, 1'b1);
    wait_drained();
    send_rack(1);
    send_rack(0);

    // Same ID twice fills the FIFO, the third response has to wait
    single_read(1, 32'h0000_a5c0, 3'd3, 1'b1);
    single_read(1, 32'h0000_3f00, 3'd3, 1'b1);
    wait_drained();
    single_read(0, 32'h0000_7740, 3'd6, 1'b1);
    repeat (10) @(negedge clk_i);
    send_rack(1);
    wait_drained();
    send_rack(1);
    send_rack(0);
    repeat (2) @(negedge clk_i);

    if (ack_count == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      stop_with_failure("Acknowledgements still owed at end of test");
    end
  end

endmodule

/* project.f */
verilog/ccu_pkg.sv
verilog/ccu_track_if.sv
verilog/rd_port_mux.sv
verilog/cm_addr_queue.sv
verilog/rack_tracker.sv
verilog/ccu_read_top.sv
verification/tb_ccu_read.sv
